//--- project.f
src/mips_pkg.sv
src/cpu_phase_seq.sv
src/instr_decode.sv
src/alu.sv
src/reg_file.sv
src/pc_unit.sv
src/mem_xfer.sv
src/mips_cpu_bus.sv
verif/mips_cpu_bus_props.sv
verif/mips_cpu_bus_tb.sv

//--- Bender.yml
package:
  name: mips_cpu_bus

sources:
  - files:
      - src/mips_pkg.sv
      - src/cpu_phase_seq.sv
      - src/instr_decode.sv
      - src/alu.sv
      - src/reg_file.sv
      - src/pc_unit.sv
      - src/mem_xfer.sv
      - src/mips_cpu_bus.sv
  - target: test
    files:
      - verif/mips_cpu_bus_props.sv
      - verif/mips_cpu_bus_tb.sv

//--- verif/mips_cpu_bus_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mips_cpu_bus_tb;
    import mips_pkg::*;

    localparam word_t RESET_VECTOR = 32'hBFC00000;
    localparam logic [5:0] OP_JAL = 6'h03, OP_BEQ = 6'h04, OP_BNE = 6'h05,
        OP_ADDIU = 6'h09, OP_ORI = 6'h0D, OP_LUI = 6'h0F, OP_LW = 6'h23, OP_SW = 6'h2B;
    localparam logic [5:0] FN_SLL = 6'h00, FN_SRL = 6'h02, FN_SRA = 6'h03, FN_JR = 6'h08,
        FN_ADDU = 6'h21, FN_SUBU = 6'h23, FN_AND = 6'h24, FN_XOR = 6'h26,
        FN_SLT = 6'h2A, FN_SLTU = 6'h2B;
    // Instructions executed over all runs, three cycles each, wait states up to 4x
    localparam int INSTR_TOTAL = 2 + 2 * 21 + 2 * 7 + 21;
    localparam int CYCLE_LIMIT = INSTR_TOTAL * 3 * 4 + 6 * 30;

    logic        clk, reset, waitrequest, ws_enable, active, read, write;
    logic [3:0]  byteenable, last_wr_be;
    word_t       register_v0, address, writedata, readdata, last_wr_addr;
    word_t       mem [logic [29:0]];
    word_t       program_q[$];
    logic [15:0] lfsr;
    int          errors = 0;
    int          write_count = 0;
    int          cycle_count = 0;

    mips_cpu_bus #(.RESET_VECTOR(RESET_VECTOR)) UUT (
        .clk(clk), .reset(reset), .active(active), .register_v0(register_v0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic word_t mem_word(input word_t addr);
        if (mem.exists(addr[31:2]))
            return mem[addr[31:2]];
        return addr ^ 32'h5EEDF00D;  // fill pattern for unwritten words
    endfunction

    // Zero latency memory, writes land on the completing edge
    assign readdata = (read && !waitrequest) ? mem_word(address) : 32'h0;

    always @(posedge clk) begin
        if (write && !waitrequest) begin
            mem[address[31:2]] = writedata;
            write_count = write_count + 1;
            last_wr_addr = address;
            last_wr_be = byteenable;
        end
    end

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
    endfunction

    initial begin
        waitrequest = 1'b0;
        lfsr = 16'd49314;
        forever begin
            @(negedge clk);
            if (ws_enable) begin
                waitrequest = lfsr[0];
                lfsr = lfsr_step(lfsr);
            end else begin
                waitrequest = 1'b0;
            end
        end
    end

    function automatic word_t encode_r(input logic [4:0] rs, rt, rd, sh, input logic [5:0] fn);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t encode_i(input logic [5:0] op, input logic [4:0] rs, rt,
                                       input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic emit(input word_t w);
        program_q.push_back(w);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    // Places the queued program at the reset vector while the bus is idle,
    // then holds the CPU in reset so the first fetch sees the new program
    task automatic start_program(input logic waits);
        word_t addr;
        mem.delete();
        for (int i = 0; i < program_q.size(); i++) begin
            addr = RESET_VECTOR + 4 * i;
            mem[addr[31:2]] = program_q[i];
        end
        program_q.delete();
        @(negedge clk);
        reset = 1'b1;
        ws_enable = waits;
        repeat (3) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic wait_for_halt();
        word_t v0_at_halt;
        while (active)
            @(negedge clk);
        v0_at_halt = register_v0;
        repeat (20) begin
            @(negedge clk);
            if (read || write) begin
                errors++;
                $display("bus access after halt at address %h", address);
            end
        end
        check_word("register_v0 after halt", register_v0, v0_at_halt);
    endtask

    task automatic test_reset();
        emit(encode_r(5'd0, 5'd0, 5'd0, 5'd0, FN_JR));
        emit(encode_i(OP_ADDIU, 5'd0, 5'd2, 16'h1234));
        start_program(1'b0);
        if (active !== 1'b1 || write !== 1'b0 || read !== 1'b1) begin
            errors++;
            $display("error: active/write/read = %h/%h/%h, expected 1/0/1", active, write, read);
        end
        check_word("address", address, RESET_VECTOR);
        wait_for_halt();
        check_word("register_v0", register_v0, 32'h1234);
    endtask

    task automatic test_arith(input logic waits);
        word_t r8, r9, r10, r11, r12, r13, r14, r15, exp;
        emit(encode_i(OP_LUI, 5'd0, 5'd8, 16'h8765));
        emit(encode_i(OP_ORI, 5'd8, 5'd8, 16'h4321));
        emit(encode_i(OP_ADDIU, 5'd0, 5'd9, 16'hFFFD));
        emit(encode_r(5'd8, 5'd9, 5'd10, 5'd0, FN_ADDU));
        emit(encode_r(5'd8, 5'd9, 5'd11, 5'd0, FN_SUBU));
        emit(encode_r(5'd10, 5'd11, 5'd12, 5'd0, FN_AND));
        emit(encode_r(5'd10, 5'd11, 5'd13, 5'd0, FN_XOR));
        emit(encode_r(5'd8, 5'd9, 5'd14, 5'd0, FN_SLT));
        emit(encode_r(5'd8, 5'd9, 5'd15, 5'd0, FN_SLTU));
        emit(encode_r(5'd0, 5'd8, 5'd16, 5'd4, FN_SLL));
        emit(encode_r(5'd0, 5'd8, 5'd17, 5'd8, FN_SRL));
        emit(encode_r(5'd0, 5'd8, 5'd18, 5'd8, FN_SRA));
        emit(encode_r(5'd12, 5'd13, 5'd2, 5'd0, FN_ADDU));
        emit(encode_r(5'd2, 5'd16, 5'd2, 5'd0, FN_XOR));
        emit(encode_r(5'd2, 5'd17, 5'd2, 5'd0, FN_ADDU));
        emit(encode_r(5'd2, 5'd18, 5'd2, 5'd0, FN_XOR));
        emit(encode_r(5'd2, 5'd14, 5'd2, 5'd0, FN_ADDU));
        emit(encode_r(5'd0, 5'd15, 5'd19, 5'd1, FN_SLL));
        emit(encode_r(5'd2, 5'd19, 5'd2, 5'd0, FN_ADDU));
        emit(encode_r(5'd0, 5'd0, 5'd0, 5'd0, FN_JR));
        emit(32'h0000_0000);
        start_program(waits);
        wait_for_halt();
        r8 = 32'h87654321;
        r9 = 32'hFFFFFFFD;
        r10 = r8 + r9;
        r11 = r8 - r9;
        r12 = r10 & r11;
        r13 = r10 ^ r11;
        // Both operands negative, r8 is the more negative one
        r14 = (r8[31] && !r9[31]) || (r8[31] == r9[31] && r8 < r9) ? 32'd1 : 32'd0;
        r15 = (r8 < r9) ? 32'd1 : 32'd0;
        exp = (r12 + r13) ^ (r8 << 4);
        exp = (exp + (r8 >> 8)) ^ {{8{r8[31]}}, r8[31:8]};
        exp = exp + r14 + (r15 << 1);
        check_word("register_v0", register_v0, exp);
    endtask

    task automatic test_mem(input logic waits);
        int writes_before;
        emit(encode_i(OP_LUI, 5'd0, 5'd8, 16'h1000));
        emit(encode_i(OP_LUI, 5'd0, 5'd9, 16'hCAFE));
        emit(encode_i(OP_ORI, 5'd9, 5'd9, 16'hF00D));
        emit(encode_i(OP_SW, 5'd8, 5'd9, 16'h0008));
        emit(encode_i(OP_LW, 5'd8, 5'd2, 16'h0008));
        emit(encode_r(5'd0, 5'd0, 5'd0, 5'd0, FN_JR));
        emit(32'h0000_0000);
        writes_before = write_count;
        start_program(waits);
        wait_for_halt();
        if (write_count - writes_before != 1) begin
            errors++;
            $display("expected one bus write, saw %0d", write_count - writes_before);
        end
        check_word("write address", last_wr_addr, 32'h10000008);
        if (last_wr_be !== 4'hF) begin
            errors++;
            $display("error: byteenable = %h, expected %h", last_wr_be, 4'hF);
        end
        check_word("mem[10000008]", mem_word(32'h10000008), 32'hCAFEF00D);
        check_word("register_v0", register_v0, 32'hCAFEF00D);
    endtask

    task automatic test_control();
        word_t sub_addr;
        sub_addr = RESET_VECTOR + 20 * 4;
        emit(encode_i(OP_ADDIU, 5'd0, 5'd2, 16'h0000));
        emit(encode_i(OP_ADDIU, 5'd0, 5'd8, 16'h0005));
        emit(encode_i(OP_ADDIU, 5'd0, 5'd9, 16'h0005));
        emit(encode_i(OP_BEQ, 5'd8, 5'd9, 16'd2));
        emit(encode_i(OP_ADDIU, 5'd2, 5'd2, 16'h0001));
        emit(encode_i(OP_ADDIU, 5'd2, 5'd2, 16'h0100));
        emit(encode_i(OP_BNE, 5'd8, 5'd9, 16'd2));
        emit(encode_i(OP_ADDIU, 5'd2, 5'd2, 16'h0002));
        emit(encode_i(OP_ADDIU, 5'd2, 5'd2, 16'h0004));
        emit(encode_i(OP_BEQ, 5'd8, 5'd0, 16'd1));
        emit(encode_i(OP_ADDIU, 5'd2, 5'd2, 16'h0008));
        emit(encode_i(OP_BNE, 5'd8, 5'd0, 16'd2));
        emit(encode_i(OP_ADDIU, 5'd2, 5'd2, 16'h0010));
        emit(encode_i(OP_ADDIU, 5'd2, 5'd2, 16'h0200));
        emit({OP_JAL, sub_addr[27:2]});
        emit(encode_i(OP_ADDIU, 5'd2, 5'd2, 16'h0020));
        // Return point, adds the link offset from the reset vector
        emit(encode_i(OP_LUI, 5'd0, 5'd11, 16'hBFC0));
        emit(encode_r(5'd31, 5'd11, 5'd12, 5'd0, FN_SUBU));
        emit(encode_r(5'd0, 5'd0, 5'd0, 5'd0, FN_JR));
        emit(encode_r(5'd2, 5'd12, 5'd2, 5'd0, FN_ADDU));
        // Subroutine
        emit(encode_i(OP_ADDIU, 5'd2, 5'd2, 16'h0040));
        emit(encode_r(5'd31, 5'd0, 5'd0, 5'd0, FN_JR));
        emit(encode_i(OP_ADDIU, 5'd2, 5'd2, 16'h0080));
        start_program(1'b0);
        wait_for_halt();
        check_word("register_v0", register_v0,
                   32'h00FF + (RESET_VECTOR + 14 * 4 + 8 - 32'hBFC00000));
    endtask

    initial begin
        reset = 1'b1;
        ws_enable = 1'b0;
        test_reset();
        test_arith(1'b0);
        test_mem(1'b0);
        test_control();
        test_arith(1'b1);
        test_mem(1'b1);
        $display("errors: %0d in checks, %0d in assertions", errors, UUT.u_props.assert_errors);
        if (errors == 0 && UUT.u_props.assert_errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/mips_cpu_bus_props.sv
`timescale 1ns/10ps
`default_nettype none

module mips_cpu_bus_props (
    input logic        clk,
    input logic        reset,
    input logic        active,
    input logic        read,
    input logic        write,
    input logic        waitrequest,
    input logic [31:0] address,
    input logic [31:0] writedata,
    input logic [3:0]  byteenable
);
    // Number of failed assertions, collected by the testbench summary
    int assert_errors = 0;

    a_no_read_write: assert property (@(posedge clk) disable iff (reset)
        !(read && write))
        else begin
            assert_errors++;
            $error("read and write asserted together");
        end

    // A stalled access keeps its address and control until it completes
    a_hold_on_wait: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=> $stable(address) && $stable(read)
            && $stable(write) && $stable(writedata) && $stable(byteenable))
        else begin
            assert_errors++;
            $error("bus access changed while waitrequest was high");
        end

    a_idle_when_halted: assert property (@(posedge clk) disable iff (reset)
        !active |-> !read && !write)
        else begin
            assert_errors++;
            $error("bus access while the CPU is halted");
        end

endmodule

bind mips_cpu_bus mips_cpu_bus_props u_props (
    .clk(clk), .reset(reset), .active(active), .read(read), .write(write),
    .waitrequest(waitrequest), .address(address), .writedata(writedata),
    .byteenable(byteenable)
);

`default_nettype wire

//--- src/mips_cpu_bus.sv
`timescale 1ns/10ps
`default_nettype none

module mips_cpu_bus #(
    parameter mips_pkg::word_t RESET_VECTOR = 32'hBFC00000
) (
    input  logic            clk,
    input  logic            reset,
    output logic            active,
    output mips_pkg::word_t register_v0,

    // Avalon memory-mapped master
    output mips_pkg::word_t address,
    output logic            write,
    output logic            read,
    input  logic            waitrequest,
    output mips_pkg::word_t writedata,
    output logic [3:0]      byteenable,
    input  mips_pkg::word_t readdata
);
    import mips_pkg::*;

    logic        fetch, exec1, exec2;
    logic        fetch_done, mem_busy, halted, equal;
    logic        reg_write_en, is_load, is_store, alu_uses_imm;
    instr_code_t instr_code;
    reg_idx_t    rs_idx, rt_idx, dest_idx, shamt;
    word_t       immediate, rdata_word, load_data, pc;
    word_t       rs_data, rt_data, alu_a, alu_b, alu_result, wr_data;
    logic [25:0] jump_index;

    assign active = ~halted;

    // JAL computes its link address as pc + 8 through the ALU
    assign alu_a = (instr_code == IC_JAL) ? pc : rs_data;

    always_comb begin
        if (instr_code == IC_JAL)
            alu_b = 32'd8;
        else if (alu_uses_imm)
            alu_b = immediate;
        else
            alu_b = rt_data;
    end

    assign wr_data = is_load ? load_data : alu_result;

    cpu_phase_seq u_seq (
        .clk(clk), .reset(reset), .stall(mem_busy | halted),
        .fetch(fetch), .exec1(exec1), .exec2(exec2)
    );

    instr_decode u_dec (
        .clk(clk), .reset(reset), .fetch(fetch), .fetch_done(fetch_done),
        .rdata_word(rdata_word), .instr_code(instr_code), .rs_idx(rs_idx),
        .rt_idx(rt_idx), .dest_idx(dest_idx), .shamt(shamt), .immediate(immediate),
        .jump_index(jump_index), .reg_write_en(reg_write_en), .is_load(is_load),
        .is_store(is_store), .alu_uses_imm(alu_uses_imm)
    );

    reg_file u_regs (
        .clk(clk), .reset(reset), .write_en(reg_write_en & exec2),
        .rs_idx(rs_idx), .rt_idx(rt_idx), .wr_idx(dest_idx), .wr_data(wr_data),
        .rs_data(rs_data), .rt_data(rt_data), .v0(register_v0)
    );

    alu u_alu (
        .a(alu_a), .b(alu_b), .shamt(shamt), .op(instr_code),
        .result(alu_result), .equal(equal)
    );

    pc_unit #(.RESET_VECTOR(RESET_VECTOR)) u_pc (
        .clk(clk), .reset(reset), .exec2(exec2), .op(instr_code),
        .immediate(immediate), .jump_index(jump_index), .rs_data(rs_data),
        .equal(equal), .pc(pc), .halted(halted)
    );

    mem_xfer u_mem (
        .clk(clk), .reset(reset), .fetch(fetch), .exec1(exec1),
        .is_load(is_load), .is_store(is_store), .halted(halted), .pc(pc),
        .alu_result(alu_result), .store_data(rt_data), .waitrequest(waitrequest),
        .readdata(readdata), .address(address), .read(read), .write(write),
        .writedata(writedata), .byteenable(byteenable), .rdata_word(rdata_word),
        .fetch_done(fetch_done), .mem_busy(mem_busy), .load_data(load_data)
    );

endmodule

`default_nettype wire

//--- src/mem_xfer.sv
`timescale 1ns/10ps
`default_nettype none

module mem_xfer (
    input  logic            clk,
    input  logic            reset,
    input  logic            fetch,
    input  logic            exec1,
    input  logic            is_load,
    input  logic            is_store,
    input  logic            halted,
    input  mips_pkg::word_t pc,
    input  mips_pkg::word_t alu_result,
    input  mips_pkg::word_t store_data,
    input  logic            waitrequest,
    input  mips_pkg::word_t readdata,
    output mips_pkg::word_t address,
    output logic            read,
    output logic            write,
    output mips_pkg::word_t writedata,
    output logic [3:0]      byteenable,
    output mips_pkg::word_t rdata_word,
    output logic            fetch_done,
    output logic            mem_busy,
    output mips_pkg::word_t load_data
);
    import mips_pkg::*;

    logic data_phase;
    logic access;

    assign data_phase = exec1 && (is_load || is_store) && !halted;

    always_comb begin
        address = '0;
        read    = 1'b0;
        write   = 1'b0;
        if (fetch && !halted) begin
            address = pc;
            read    = 1'b1;
        end else if (data_phase) begin
            address = alu_result;
            read    = is_load;
            write   = is_store;
        end
    end

    assign access     = read || write;
    assign writedata  = write ? store_data : '0;
    // Full word accesses only
    assign byteenable = access ? 4'b1111 : 4'b0000;

    // Zero latency bus, so readdata is valid on the completing cycle
    assign rdata_word = readdata;
    assign fetch_done = fetch && read && !waitrequest;
    assign mem_busy   = access && waitrequest;

    always_ff @(posedge clk) begin
        if (reset)
            load_data <= '0;
        else if (data_phase && read && !waitrequest)
            load_data <= readdata;
    end

endmodule

`default_nettype wire

//--- src/pc_unit.sv
`timescale 1ns/10ps
`default_nettype none

module pc_unit #(
    parameter mips_pkg::word_t RESET_VECTOR = 32'hBFC00000
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  exec2,
    input  mips_pkg::instr_code_t op,
    input  mips_pkg::word_t       immediate,
    input  logic [25:0]           jump_index,
    input  mips_pkg::word_t       rs_data,
    input  logic                  equal,
    output mips_pkg::word_t       pc,
    output logic                  halted
);
    import mips_pkg::*;

    word_t next_pc;
    word_t pc_plus4;
    word_t target;
    logic  taken;

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        taken  = 1'b0;
        target = pc_plus4 + {immediate[29:0], 2'b00};
        case (op)
            IC_BEQ: taken = equal;
            IC_BNE: taken = !equal;
            IC_J, IC_JAL: begin
                taken  = 1'b1;
                target = {pc_plus4[31:28], jump_index, 2'b00};
            end
            IC_JR: begin
                taken  = 1'b1;
                target = rs_data;
            end
            default: taken = 1'b0;
        endcase
    end

    // next_pc already points at the delay slot when a jump resolves
    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= RESET_VECTOR;
            next_pc <= RESET_VECTOR + 32'd4;
            halted  <= 1'b0;
        end else if (exec2) begin
            pc      <= next_pc;
            next_pc <= taken ? target : next_pc + 32'd4;
            if (next_pc == '0)
                halted <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- src/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  logic               clk,
    input  logic               reset,
    input  logic               write_en,
    input  mips_pkg::reg_idx_t rs_idx,
    input  mips_pkg::reg_idx_t rt_idx,
    input  mips_pkg::reg_idx_t wr_idx,
    input  mips_pkg::word_t    wr_data,
    output mips_pkg::word_t    rs_data,
    output mips_pkg::word_t    rt_data,
    output mips_pkg::word_t    v0
);
    import mips_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (write_en && (wr_idx != 5'd0)) begin
            // Register 0 is never written so it reads as zero
            regs[wr_idx] <= wr_data;
        end
    end

    assign rs_data = regs[rs_idx];
    assign rt_data = regs[rt_idx];
    assign v0      = regs[2];

endmodule

`default_nettype wire

//--- src/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  mips_pkg::word_t       a,
    input  mips_pkg::word_t       b,
    input  mips_pkg::reg_idx_t    shamt,
    input  mips_pkg::instr_code_t op,
    output mips_pkg::word_t       result,
    output logic                  equal
);
    import mips_pkg::*;

    word_t sum;
    word_t diff;

    assign sum  = a + b;
    assign diff = a - b;

    // Branch comparison of rs against rt
    assign equal = (a == b);

    always_comb begin
        case (op)
            // Address computation for LW and SW and the JAL link share the adder
            IC_ADDU, IC_ADDIU, IC_LW, IC_SW, IC_JAL: result = sum;
            IC_SUBU:         result = diff;
            IC_AND, IC_ANDI: result = a & b;
            IC_OR, IC_ORI:   result = a | b;
            IC_XOR, IC_XORI: result = a ^ b;
            IC_SLT:          result = {31'd0, $signed(a) < $signed(b)};
            IC_SLTU:         result = {31'd0, a < b};
            // Shifts operate on rt, which arrives on B
            IC_SLL:          result = b << shamt;
            IC_SRL:          result = b >> shamt;
            IC_SRA:          result = word_t'($signed(b) >>> shamt);
            IC_LUI:          result = b;
            default:         result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/instr_decode.sv
`timescale 1ns/10ps
`default_nettype none

module instr_decode (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fetch,
    input  logic                  fetch_done,
    input  mips_pkg::word_t       rdata_word,
    output mips_pkg::instr_code_t instr_code,
    output mips_pkg::reg_idx_t    rs_idx,
    output mips_pkg::reg_idx_t    rt_idx,
    output mips_pkg::reg_idx_t    dest_idx,
    output mips_pkg::reg_idx_t    shamt,
    output mips_pkg::word_t       immediate,
    output logic [25:0]           jump_index,
    output logic                  reg_write_en,
    output logic                  is_load,
    output logic                  is_store,
    output logic                  alu_uses_imm
);
    import mips_pkg::*;

    word_t ir;

    // A cleared IR decodes as SLL $0, $0, 0 which is a NOP
    always_ff @(posedge clk) begin
        if (reset)
            ir <= '0;
        else if (fetch && fetch_done)
            ir <= rdata_word;
    end

    assign rs_idx     = ir[25:21];
    assign rt_idx     = ir[20:16];
    assign shamt      = ir[10:6];
    assign jump_index = ir[25:0];

    always_comb begin
        instr_code = IC_INVALID;
        case (ir[31:26])
            6'h00: begin
                // SPECIAL group, decoded on funct
                case (ir[5:0])
                    6'h00: instr_code = IC_SLL;
                    6'h02: instr_code = IC_SRL;
                    6'h03: instr_code = IC_SRA;
                    6'h08: instr_code = IC_JR;
                    6'h21: instr_code = IC_ADDU;
                    6'h23: instr_code = IC_SUBU;
                    6'h24: instr_code = IC_AND;
                    6'h25: instr_code = IC_OR;
                    6'h26: instr_code = IC_XOR;
                    6'h2A: instr_code = IC_SLT;
                    6'h2B: instr_code = IC_SLTU;
                    default: instr_code = IC_INVALID;
                endcase
            end
            6'h02: instr_code = IC_J;
            6'h03: instr_code = IC_JAL;
            6'h04: instr_code = IC_BEQ;
            6'h05: instr_code = IC_BNE;
            6'h09: instr_code = IC_ADDIU;
            6'h0C: instr_code = IC_ANDI;
            6'h0D: instr_code = IC_ORI;
            6'h0E: instr_code = IC_XORI;
            6'h0F: instr_code = IC_LUI;
            6'h23: instr_code = IC_LW;
            6'h2B: instr_code = IC_SW;
            default: instr_code = IC_INVALID;
        endcase
    end

    always_comb begin
        case (instr_code)
            IC_ANDI, IC_ORI, IC_XORI: immediate = {16'h0000, ir[15:0]};
            IC_LUI:                   immediate = {ir[15:0], 16'h0000};
            default:                  immediate = {{16{ir[15]}}, ir[15:0]};
        endcase
    end

    assign is_load      = (instr_code == IC_LW);
    assign is_store     = (instr_code == IC_SW);
    assign alu_uses_imm = (instr_code inside {IC_ADDIU, IC_ANDI, IC_ORI, IC_XORI,
                                              IC_LUI, IC_LW, IC_SW});

    always_comb begin
        reg_write_en = 1'b0;
        dest_idx     = ir[15:11];
        case (instr_code)
            IC_ADDU, IC_SUBU, IC_AND, IC_OR, IC_XOR, IC_SLT, IC_SLTU,
            IC_SLL, IC_SRL, IC_SRA: begin
                reg_write_en = 1'b1;
            end
            IC_ADDIU, IC_ANDI, IC_ORI, IC_XORI, IC_LUI, IC_LW: begin
                reg_write_en = 1'b1;
                dest_idx     = ir[20:16];
            end
            IC_JAL: begin
                // Link register
                reg_write_en = 1'b1;
                dest_idx     = 5'd31;
            end
            default: reg_write_en = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/cpu_phase_seq.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_phase_seq (
    input  logic clk,
    input  logic reset,
    input  logic stall,
    output logic fetch,
    output logic exec1,
    output logic exec2
);
    import mips_pkg::*;

    phase_t phase;

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= PH_FETCH;
        end else if (!stall) begin
            case (phase)
                PH_FETCH: phase <= PH_EXEC1;
                PH_EXEC1: phase <= PH_EXEC2;
                default:  phase <= PH_FETCH;
            endcase
        end
    end

    assign fetch = (phase == PH_FETCH);
    assign exec1 = (phase == PH_EXEC1);
    assign exec2 = (phase == PH_EXEC2);

endmodule

`default_nettype wire

//--- src/mips_pkg.sv
`default_nettype none

package mips_pkg;

    // Data, addresses and instruction words
    typedef logic [31:0] word_t;

    // Register index, also used for the shift amount field
    typedef logic [4:0] reg_idx_t;

    // Internal instruction code, one entry per supported instruction
    typedef enum logic [4:0] {
        IC_INVALID,
        IC_ADDU,
        IC_ADDIU,
        IC_SUBU,
        IC_AND,
        IC_OR,
        IC_XOR,
        IC_ANDI,
        IC_ORI,
        IC_XORI,
        IC_SLT,
        IC_SLTU,
        IC_SLL,
        IC_SRL,
        IC_SRA,
        IC_LUI,
        IC_LW,
        IC_SW,
        IC_BEQ,
        IC_BNE,
        IC_J,
        IC_JR,
        IC_JAL
    } instr_code_t;

    // Instruction phases of the multicycle sequence
    typedef enum logic [1:0] {
        PH_FETCH,
        PH_EXEC1,
        PH_EXEC2
    } phase_t;

endpackage

`default_nettype wire
